//--- include/neighbor_settings.svh
`ifndef NEIGHBOR_SETTINGS_SVH
`define NEIGHBOR_SETTINGS_SVH

//////////////////////////////////////////////////////////////
// Neighbor SRAM geometry
//////////////////////////////////////////////////////////////

`define NEIGHBOR_ID_W 7     // One neighbor ID.
`define NEIGHBOR_WORD_W 14  // Two IDs per SRAM row.
`define NEIGHBOR_ROW_W 6    // Row address bits.

//////////////////////////////////////////////////////////////
// Request side
//////////////////////////////////////////////////////////////

`define MAX_DEGREE 15       // Largest neighbor count.
`define NUM_EDGE_PE 4       // Requesting edge PEs.

//////////////////////////////////////////////////////////////
// Configuration bus
//////////////////////////////////////////////////////////////

`define CSR_ADDR_W 2

`endif

//--- hw/graph_mem_pkg.sv
`default_nettype none

`include "neighbor_settings.svh"

// Types for the memory side of the neighbor bank.
package graph_mem_pkg;

    // Row address into the neighbor SRAM.
    typedef logic [`NEIGHBOR_ROW_W-1:0] row_t;

    // One SRAM row, lower ID in the low half.
    typedef logic [`NEIGHBOR_WORD_W-1:0] sram_word_t;

    // A single neighbor vertex ID.
    typedef logic [`NEIGHBOR_ID_W-1:0] neighbor_id_t;

    // Statistics counters in the CSR block.
    typedef logic [15:0] counter_t;

endpackage

`default_nettype wire

//--- hw/pe_stream_pkg.sv
`default_nettype none

`include "neighbor_settings.svh"

// Types for the PE side of the neighbor bank.
package pe_stream_pkg;

    // Index of a requesting edge PE.
    typedef logic [$clog2(`NUM_EDGE_PE)-1:0] pe_tag_t;

    // Neighbor count of one list.
    typedef logic [$clog2(`MAX_DEGREE+1)-1:0] degree_t;

    // Bank controller states.
    typedef enum logic {
        idle   = 1'b0,
        stream = 1'b1
    } bank_state_t;

endpackage

`default_nettype wire

//--- hw/neighbor_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "neighbor_settings.svh"

module neighbor_sram (
    input  logic                      clk,
    input  logic                      sram_cen,
    input  graph_mem_pkg::row_t       sram_addr,
    output graph_mem_pkg::sram_word_t sram_rdata,
    input  logic                      load_en,
    input  graph_mem_pkg::row_t       load_row,
    input  graph_mem_pkg::sram_word_t load_data
);

    localparam int DEPTH = 1 << `NEIGHBOR_ROW_W;

    graph_mem_pkg::sram_word_t mem [DEPTH];

    // Reads win over the load port.
    always_ff @(posedge clk) begin
        if (!sram_cen) begin
            sram_rdata <= mem[sram_addr]; // Data valid next cycle.
        end else if (load_en) begin
            mem[load_row] <= load_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/neighbor_request_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "neighbor_settings.svh"

module neighbor_request_arbiter (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic [`NUM_EDGE_PE-1:0]                                 req,
    input  logic [`NUM_EDGE_PE*`NEIGHBOR_ROW_W-1:0]                 req_row,
    input  logic [`NUM_EDGE_PE*$bits(pe_stream_pkg::degree_t)-1:0] req_degree,
    input  logic                                                    busy,
    output logic [`NUM_EDGE_PE-1:0]                                 grant,
    output logic                                                    start,
    output graph_mem_pkg::row_t                                     start_row,
    output pe_stream_pkg::degree_t                                  start_degree,
    output pe_stream_pkg::pe_tag_t                                  start_tag
);

    localparam int NUM   = `NUM_EDGE_PE;
    localparam int ROW_W = `NEIGHBOR_ROW_W;
    localparam int DEG_W = $bits(pe_stream_pkg::degree_t);

    pe_stream_pkg::pe_tag_t last_served;
    pe_stream_pkg::pe_tag_t pick;
    logic                   found;
    logic                   issue;

    //////////////////////////////////////////////////////////////
    // Rotating priority search
    //////////////////////////////////////////////////////////////

    always_comb begin
        int idx;
        found = 1'b0;
        pick  = last_served;
        for (int i = 1; i <= NUM; i++) begin
            idx = (int'(last_served) + i) % NUM; // Start after last winner.
            if (!found && req[idx]) begin
                found = 1'b1;
                pick  = pe_stream_pkg::pe_tag_t'(idx);
            end
        end
    end

    // Skip the cycle right after a start, busy is not up yet.
    assign issue = found && !busy && !start;

    always_ff @(posedge clk) begin
        if (reset) begin
            grant       <= '0;
            start       <= 1'b0;
            last_served <= pe_stream_pkg::pe_tag_t'(NUM - 1); // PE 0 goes first.
        end else begin
            start <= issue;
            grant <= issue ? (NUM'(1) << pick) : '0;
            if (issue) begin
                last_served <= pick;
            end
        end
    end

    // Descriptor of the winner, valid with start.
    always_ff @(posedge clk) begin
        if (issue) begin
            start_row    <= req_row[pick*ROW_W +: ROW_W];
            start_degree <= req_degree[pick*DEG_W +: DEG_W];
            start_tag    <= pick;
        end
    end

endmodule

`default_nettype wire

//--- hw/neighbor_bank_csr.sv
`timescale 1ns/1ps
`default_nettype none

`include "neighbor_settings.svh"

module neighbor_bank_csr (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`CSR_ADDR_W-1:0]  cfg_addr,
    input  logic                    cfg_wr,
    input  logic [15:0]             cfg_wdata,
    output logic [15:0]             cfg_rdata,
    output graph_mem_pkg::row_t     base_row,
    input  logic                    burst_done,
    input  logic                    word_sent
);

    localparam logic [`CSR_ADDR_W-1:0] ADDR_BASE  = 'd0;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_BURST = 'd1;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_WORDS = 'd2;
    localparam logic [`CSR_ADDR_W-1:0] ADDR_CLEAR = 'd3;

    graph_mem_pkg::counter_t burst_cnt;
    graph_mem_pkg::counter_t word_cnt;
    logic                    clear_stats;

    // Holds at all ones.
    function automatic graph_mem_pkg::counter_t sat_inc(
        input graph_mem_pkg::counter_t cnt,
        input logic                    pulse
    );
        if (pulse && cnt != '1) begin
            return cnt + 1'b1;
        end
        return cnt;
    endfunction

    assign clear_stats = cfg_wr && (cfg_addr == ADDR_CLEAR);

    always_ff @(posedge clk) begin
        if (reset) begin
            base_row  <= '0;
            burst_cnt <= '0;
            word_cnt  <= '0;
        end else begin
            if (cfg_wr && cfg_addr == ADDR_BASE) begin
                base_row <= cfg_wdata[`NEIGHBOR_ROW_W-1:0];
            end
            if (clear_stats) begin
                burst_cnt <= '0; // Clear beats a same-cycle pulse.
                word_cnt  <= '0;
            end else begin
                burst_cnt <= sat_inc(burst_cnt, burst_done);
                word_cnt  <= sat_inc(word_cnt, word_sent);
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            ADDR_BASE:  cfg_rdata = 16'(base_row);
            ADDR_BURST: cfg_rdata = burst_cnt;
            ADDR_WORDS: cfg_rdata = word_cnt;
            default:    cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/neighbor_bank_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "neighbor_settings.svh"

module neighbor_bank_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  graph_mem_pkg::row_t       start_row,
    input  pe_stream_pkg::degree_t    start_degree,
    input  pe_stream_pkg::pe_tag_t    start_tag,
    input  graph_mem_pkg::row_t       base_row,
    output logic                      sram_cen,
    output graph_mem_pkg::row_t       sram_addr,
    input  graph_mem_pkg::sram_word_t sram_rdata,
    output logic                      busy,
    output logic                      out_valid,
    output logic                      out_sos,
    output logic                      out_eos,
    output pe_stream_pkg::pe_tag_t    out_tag,
    output pe_stream_pkg::degree_t    out_degree,
    output graph_mem_pkg::sram_word_t out_data,
    output logic                      burst_done,
    output logic                      word_sent
);

    // One spare bit, the counters reach MAX_DEGREE plus one.
    localparam int CNT_W = $bits(pe_stream_pkg::degree_t) + 1;

    pe_stream_pkg::bank_state_t state, nx_state;
    pe_stream_pkg::pe_tag_t     tag_q, nx_tag;
    pe_stream_pkg::degree_t     deg_q, nx_deg;
    logic [CNT_W-1:0]           iss_cnt, nx_iss_cnt;
    logic [CNT_W-1:0]           out_cnt, nx_out_cnt;
    logic                       nx_cen;
    graph_mem_pkg::row_t        nx_addr;
    logic                       rd_valid;
    logic                       last_row;
    graph_mem_pkg::neighbor_id_t lo_id;
    logic                       nx_valid, nx_sos, nx_eos;
    graph_mem_pkg::sram_word_t  nx_data;

    assign busy     = (state == pe_stream_pkg::stream);
    assign lo_id    = sram_rdata[`NEIGHBOR_ID_W-1:0];
    assign last_row = (out_cnt + CNT_W'(2)) >= CNT_W'(deg_q);

    //////////////////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////////////////

    always_comb begin
        nx_state   = state;
        nx_tag     = tag_q;
        nx_deg     = deg_q;
        nx_iss_cnt = iss_cnt;
        nx_out_cnt = out_cnt;
        nx_cen     = 1'b1;
        nx_addr    = sram_addr;
        nx_valid   = 1'b0;
        nx_sos     = 1'b0;
        nx_eos     = 1'b0;
        nx_data    = sram_rdata;
        case (state)
            pe_stream_pkg::idle: begin
                if (start) begin
                    nx_state   = pe_stream_pkg::stream;
                    nx_cen     = 1'b0;
                    nx_addr    = base_row + start_row;
                    nx_tag     = start_tag;
                    nx_deg     = (start_degree == '0) ? 'd2 : start_degree; // Zero means two.
                    nx_iss_cnt = CNT_W'(2);
                    nx_out_cnt = '0;
                end
            end
            pe_stream_pkg::stream: begin
                // Read side, one row per cycle until the list is covered.
                if (iss_cnt < CNT_W'(deg_q)) begin
                    nx_cen     = 1'b0;
                    nx_addr    = sram_addr + 1'b1;
                    nx_iss_cnt = iss_cnt + CNT_W'(2);
                end
                // Output side, follows the reads by one cycle.
                if (rd_valid) begin
                    nx_valid   = 1'b1;
                    nx_sos     = (out_cnt == '0);
                    nx_eos     = last_row;
                    nx_out_cnt = out_cnt + CNT_W'(2);
                    if (last_row) begin
                        nx_state = pe_stream_pkg::idle;
                        if (deg_q[0]) begin
                            nx_data = {graph_mem_pkg::neighbor_id_t'(0), lo_id}; // Odd tail.
                        end
                    end
                end
            end
            default: nx_state = pe_stream_pkg::idle;
        endcase
    end

    //////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= pe_stream_pkg::idle;
            sram_cen  <= 1'b1;
            sram_addr <= '0;
            iss_cnt   <= '0;
            out_cnt   <= '0;
            rd_valid  <= 1'b0;
            out_valid <= 1'b0;
            out_sos   <= 1'b0;
            out_eos   <= 1'b0;
        end else begin
            state     <= nx_state;
            sram_cen  <= nx_cen;
            sram_addr <= nx_addr;
            iss_cnt   <= nx_iss_cnt;
            out_cnt   <= nx_out_cnt;
            rd_valid  <= !sram_cen; // SRAM data lands this edge.
            out_valid <= nx_valid;
            out_sos   <= nx_sos;
            out_eos   <= nx_eos;
        end
    end

    always_ff @(posedge clk) begin
        tag_q      <= nx_tag;
        deg_q      <= nx_deg;
        out_tag    <= nx_tag;
        out_degree <= nx_deg;
        out_data   <= nx_data;
    end

    // Statistics strobes for the CSR block.
    assign word_sent  = out_valid;
    assign burst_done = out_valid && out_eos;

endmodule

`default_nettype wire

//--- hw/neighbor_bank_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "neighbor_settings.svh"

module neighbor_bank_top (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic [`NUM_EDGE_PE-1:0]                                 req,
    input  logic [`NUM_EDGE_PE*`NEIGHBOR_ROW_W-1:0]                 req_row,
    input  logic [`NUM_EDGE_PE*$bits(pe_stream_pkg::degree_t)-1:0] req_degree,
    output logic [`NUM_EDGE_PE-1:0]                                 grant,
    input  logic [`CSR_ADDR_W-1:0]                                  cfg_addr,
    input  logic                                                    cfg_wr,
    input  logic [15:0]                                             cfg_wdata,
    output logic [15:0]                                             cfg_rdata,
    input  logic                                                    load_en,
    input  graph_mem_pkg::row_t                                     load_row,
    input  graph_mem_pkg::sram_word_t                               load_data,
    output logic                                                    out_valid,
    output logic                                                    out_sos,
    output logic                                                    out_eos,
    output pe_stream_pkg::pe_tag_t                                  out_tag,
    output pe_stream_pkg::degree_t                                  out_degree,
    output graph_mem_pkg::sram_word_t                               out_data
);

    logic                      start;
    graph_mem_pkg::row_t       start_row;
    pe_stream_pkg::degree_t    start_degree;
    pe_stream_pkg::pe_tag_t    start_tag;
    logic                      busy;
    graph_mem_pkg::row_t       base_row;
    logic                      burst_done;
    logic                      word_sent;
    logic                      sram_cen;
    graph_mem_pkg::row_t       sram_addr;
    graph_mem_pkg::sram_word_t sram_rdata;

    neighbor_request_arbiter u_arbiter (
        .clk, .reset, .req, .req_row, .req_degree, .busy,
        .grant, .start, .start_row, .start_degree, .start_tag
    );

    neighbor_bank_csr u_csr (
        .clk, .reset, .cfg_addr, .cfg_wr, .cfg_wdata, .cfg_rdata,
        .base_row, .burst_done, .word_sent
    );

    neighbor_bank_ctrl u_ctrl (
        .clk, .reset, .start, .start_row, .start_degree, .start_tag, .base_row,
        .sram_cen, .sram_addr, .sram_rdata, .busy,
        .out_valid, .out_sos, .out_eos, .out_tag, .out_degree, .out_data,
        .burst_done, .word_sent
    );

    neighbor_sram u_sram (
        .clk, .sram_cen, .sram_addr, .sram_rdata, .load_en, .load_row, .load_data
    );

endmodule

`default_nettype wire

//--- verif/neighbor_bank_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "neighbor_settings.svh"

module neighbor_bank_tb;

    localparam int CLK_PERIOD = 20;
    localparam int NUM        = `NUM_EDGE_PE;
    localparam int ROW_W      = `NEIGHBOR_ROW_W;
    localparam int DEG_W      = $bits(pe_stream_pkg::degree_t);
    localparam int ID_W       = `NEIGHBOR_ID_W;
    localparam int DEPTH      = 1 << `NEIGHBOR_ROW_W;
    // 14 bursts carrying 44 words, plus SRAM load and CSR traffic.
    localparam int BURST_CYCLES    = 44 + 14 * 6;
    localparam int WATCHDOG_CYCLES = BURST_CYCLES + DEPTH + 300;

    typedef struct {
        int                        cyc;
        pe_stream_pkg::pe_tag_t    tag;
        logic                      sos;
        logic                      eos;
        pe_stream_pkg::degree_t    deg;
        graph_mem_pkg::sram_word_t data;
    } word_obs_t;

    logic                      clk;
    logic                      reset;
    logic [NUM-1:0]            req;
    logic [NUM*ROW_W-1:0]      req_row;
    logic [NUM*DEG_W-1:0]      req_degree;
    logic [NUM-1:0]            grant;
    logic [`CSR_ADDR_W-1:0]    cfg_addr;
    logic                      cfg_wr;
    logic [15:0]               cfg_wdata;
    logic [15:0]               cfg_rdata;
    logic                      load_en;
    graph_mem_pkg::row_t       load_row;
    graph_mem_pkg::sram_word_t load_data;
    logic                      out_valid;
    logic                      out_sos;
    logic                      out_eos;
    pe_stream_pkg::pe_tag_t    out_tag;
    pe_stream_pkg::degree_t    out_degree;
    graph_mem_pkg::sram_word_t out_data;

    graph_mem_pkg::sram_word_t mirror [DEPTH]; // Model of the SRAM contents.
    graph_mem_pkg::row_t       cur_base;
    logic [31:0]               rng;
    logic                      in_burst;
    int                        cyc;
    int                        last_pe;
    int                        err_count;
    int                        tests_passed;
    int                        tests_failed;
    word_obs_t                 words_q[$];
    int                        grant_pe_q[$];
    int                        grant_cyc_q[$];

    neighbor_bank_top uut (
        .clk, .reset, .req, .req_row, .req_degree, .grant,
        .cfg_addr, .cfg_wr, .cfg_wdata, .cfg_rdata,
        .load_en, .load_row, .load_data,
        .out_valid, .out_sos, .out_eos, .out_tag, .out_degree, .out_data
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // A PE lets go of its request once granted.
    always @(posedge clk) begin
        for (int i = 0; i < NUM; i++) begin
            if (grant[i]) begin
                req[i] <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        word_obs_t w;
        if (!reset) begin
            if ($countones(grant) > 1) begin
                $display("Grant went to more than one PE at cycle %0d", cyc);
                err_count++;
            end
            for (int i = 0; i < NUM; i++) begin
                if (grant[i]) begin
                    grant_pe_q.push_back(i);
                    grant_cyc_q.push_back(cyc);
                end
            end
            if (out_valid) begin
                if (out_sos && in_burst) begin
                    $display("New burst began before the previous one ended, cycle %0d", cyc);
                    err_count++;
                end
                if (!out_sos && !in_burst) begin
                    $display("Stream word arrived outside any burst, cycle %0d", cyc);
                    err_count++;
                end
                w.cyc  = cyc;
                w.tag  = out_tag;
                w.sos  = out_sos;
                w.eos  = out_eos;
                w.deg  = out_degree;
                w.data = out_data;
                words_q.push_back(w);
                in_burst = !out_eos;
            end else if (in_burst) begin
                $display("Gap inside a burst at cycle %0d", cyc);
                err_count++;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int burst_words(input int deg);
        int n;
        n = (deg == 0) ? 2 : deg; // Zero counts as two.
        return (n + 1) / 2;
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("ERR %s %s: expected 0x%0h, actual 0x%0h", name, what, expected, actual);
        err_count++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("PASS %s", name);
            tests_passed++;
        end else begin
            $display("FAIL %s, %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus and PE drivers
    ////////////////////////////////////////////////////////////

    task automatic load_sram();
        for (int r = 0; r < DEPTH; r++) begin
            rng = xorshift32(rng);
            mirror[r] = rng[`NEIGHBOR_WORD_W-1:0];
            @(posedge clk);
            load_en   <= 1'b1;
            load_row  <= graph_mem_pkg::row_t'(r);
            load_data <= rng[`NEIGHBOR_WORD_W-1:0];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic cfg_write(input int addr, input logic [15:0] data);
        @(posedge clk);
        cfg_addr  <= `CSR_ADDR_W'(addr);
        cfg_wr    <= 1'b1;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr <= 1'b0;
    endtask

    task automatic cfg_read(input int addr, output logic [15:0] data);
        @(posedge clk);
        cfg_addr <= `CSR_ADDR_W'(addr);
        @(negedge clk);
        data = cfg_rdata; // Combinational read.
    endtask

    // Called on a rising edge.
    task automatic post_request(input int pe, input int row, input int deg);
        req[pe]                       <= 1'b1;
        req_row[pe*ROW_W +: ROW_W]    <= ROW_W'(row);
        req_degree[pe*DEG_W +: DEG_W] <= DEG_W'(deg);
    endtask

    task automatic wait_words(input string name, input int n);
        int waited;
        waited = 0;
        while (words_q.size() < n && waited < 64) begin
            @(negedge clk);
            waited++;
        end
        if (words_q.size() < n) begin
            $display("%s: only %0d of %0d stream words arrived", name, words_q.size(), n);
            err_count++;
        end
    endtask

    task automatic check_burst(input string name, input int pe, input int row, input int deg);
        int                        n;
        int                        nw;
        int                        g_pe;
        int                        prev_cyc;
        graph_mem_pkg::sram_word_t expect_word;
        word_obs_t                 w;
        n  = (deg == 0) ? 2 : deg;
        nw = burst_words(deg);
        if (grant_pe_q.size() == 0) begin
            $display("%s: PE %0d was never granted", name, pe);
            err_count++;
            return;
        end
        g_pe     = grant_pe_q.pop_front();
        prev_cyc = grant_cyc_q.pop_front() + 2; // First word 3 cycles after grant.
        if (g_pe != pe) report_mismatch(name, "granted PE", pe, g_pe);
        for (int k = 0; k < nw; k++) begin
            if (words_q.size() == 0) begin
                $display("%s: word %0d of the burst for PE %0d is missing", name, k, pe);
                err_count++;
                return;
            end
            w = words_q.pop_front();
            expect_word = mirror[(int'(cur_base) + row + k) % DEPTH];
            if (k == nw - 1 && n % 2 == 1) begin
                expect_word[`NEIGHBOR_WORD_W-1:ID_W] = '0; // Odd tail.
            end
            if (w.cyc != prev_cyc + 1) report_mismatch(name, "word cycle", prev_cyc + 1, w.cyc);
            if (w.data !== expect_word) report_mismatch(name, "data", expect_word, w.data);
            if (w.tag !== pe) report_mismatch(name, "tag", pe, w.tag);
            if (w.deg !== n) report_mismatch(name, "degree", n, w.deg);
            if (w.sos !== (k == 0)) report_mismatch(name, "sos", k == 0, w.sos);
            if (w.eos !== (k == nw - 1)) report_mismatch(name, "eos", k == nw - 1, w.eos);
            prev_cyc = w.cyc;
        end
        last_pe = pe;
    endtask

    task automatic serve_one(input string name, input int pe, input int row, input int deg);
        @(posedge clk);
        post_request(pe, row, deg);
        wait_words(name, burst_words(deg));
        check_burst(name, pe, row, deg);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_state();
        string       name;
        int          errs;
        logic [15:0] rd;
        name = "reset_state";
        errs = err_count;
        repeat (4) begin
            @(negedge clk);
            if (out_valid !== 1'b0) report_mismatch(name, "out_valid", 0, out_valid);
            if (grant !== '0) report_mismatch(name, "grant", 0, grant);
        end
        for (int a = 0; a < 3; a++) begin
            cfg_read(a, rd);
            if (rd !== 16'h0) report_mismatch(name, $sformatf("register %0d", a), 0, rd);
        end
        finish_test(name, errs);
    endtask

    task automatic single_word_bursts();
        int errs;
        errs = err_count;
        serve_one("single_word_bursts", 0, 5, 1);
        serve_one("single_word_bursts", 1, 12, 2);
        serve_one("single_word_bursts", 2, 33, 0);
        finish_test("single_word_bursts", errs);
    endtask

    task automatic long_bursts();
        int errs;
        errs = err_count;
        serve_one("long_bursts", 3, 2, 7);
        serve_one("long_bursts", 1, 20, 15);
        finish_test("long_bursts", errs);
    endtask

    task automatic round_robin_order();
        string name;
        int    errs;
        int    first;
        int    total;
        int    pe;
        int    rows [NUM];
        int    degs [NUM];
        name  = "round_robin_order";
        errs  = err_count;
        rows  = '{40, 3, 17, 58};
        degs  = '{3, 5, 4, 9};
        first = (last_pe + 1) % NUM; // Rotation resumes after the last winner.
        total = 0;
        @(posedge clk);
        for (int i = 0; i < NUM; i++) begin
            post_request(i, rows[i], degs[i]);
            total += burst_words(degs[i]);
        end
        wait_words(name, total);
        for (int j = 0; j < NUM; j++) begin
            pe = (first + j) % NUM;
            check_burst(name, pe, rows[pe], degs[pe]);
        end
        finish_test(name, errs);
    endtask

    task automatic partition_base();
        string       name;
        int          errs;
        logic [15:0] rd;
        name = "partition_base";
        errs = err_count;
        cfg_write(0, 16'd20);
        cur_base = graph_mem_pkg::row_t'(20);
        cfg_read(0, rd);
        if (rd !== 16'd20) report_mismatch(name, "base_row readback", 20, rd);
        serve_one(name, 0, 7, 6);
        serve_one(name, 1, 50, 9); // Wraps past the last row.
        cfg_write(0, 16'd0);
        cur_base = '0;
        finish_test(name, errs);
    endtask

    task automatic statistics_counters();
        string       name;
        int          errs;
        int          bursts;
        int          words;
        logic [15:0] rd;
        int          degs [3];
        name   = "statistics_counters";
        errs   = err_count;
        degs   = '{4, 11, 1};
        bursts = 0;
        words  = 0;
        cfg_write(3, 16'h0);
        for (int i = 0; i < 3; i++) begin
            serve_one(name, i + 1, 9 + 12 * i, degs[i]);
            bursts++;
            words += burst_words(degs[i]);
        end
        repeat (2) @(posedge clk);
        cfg_read(1, rd);
        if (rd !== 16'(bursts)) report_mismatch(name, "burst count", bursts, rd);
        cfg_read(2, rd);
        if (rd !== 16'(words)) report_mismatch(name, "word count", words, rd);
        cfg_write(3, 16'hffff);
        cfg_read(1, rd);
        if (rd !== 16'h0) report_mismatch(name, "burst count after clear", 0, rd);
        cfg_read(2, rd);
        if (rd !== 16'h0) report_mismatch(name, "word count after clear", 0, rd);
        finish_test(name, errs);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles without the tests finishing",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        req          = '0;
        req_row      = '0;
        req_degree   = '0;
        cfg_addr     = '0;
        cfg_wr       = 1'b0;
        cfg_wdata    = '0;
        load_en      = 1'b0;
        load_row     = '0;
        load_data    = '0;
        rng          = 32'hed5f;
        cur_base     = '0;
        in_burst     = 1'b0;
        cyc          = 0;
        last_pe      = NUM - 1;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        reset_state();
        load_sram();
        single_word_bursts();
        long_bursts();
        round_robin_order();
        partition_base();
        statistics_counters();
        repeat (4) @(posedge clk);
        if (words_q.size() != 0 || grant_pe_q.size() != 0) begin
            $display("Unexpected extra grants or stream words at the end of the run");
            err_count++;
        end
        $display("Tests passed=%0d failed=%0d", tests_passed, tests_failed);
        if (err_count == 0 && tests_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
hw/graph_mem_pkg.sv
hw/pe_stream_pkg.sv
hw/neighbor_sram.sv
hw/neighbor_request_arbiter.sv
hw/neighbor_bank_csr.sv
hw/neighbor_bank_ctrl.sv
hw/neighbor_bank_top.sv
verif/neighbor_bank_tb.sv

//--- Makefile
# Verilator build and run for the neighbor bank testbench.

.PHONY: all run lint clean

all: run

obj_dir/Vneighbor_bank_tb: flist.f $(wildcard hw/*.sv) $(wildcard include/*.svh) verif/neighbor_bank_tb.sv
	verilator --binary --timing -Wno-fatal -j 0 --top-module neighbor_bank_tb -f flist.f

run: obj_dir/Vneighbor_bank_tb
	./obj_dir/Vneighbor_bank_tb | tee sim.log
	@grep -q "Test completed successfully" sim.log || { echo "Simulation failed, see sim.log"; exit 1; }

lint:
	verilator --lint-only -Wall --timing --top-module neighbor_bank_top -f flist.f

clean:
	rm -rf obj_dir sim.log
